/* vlog.f */
+incdir+hdl
hdl/cam_tracker_pkg.sv
hdl/pixel_reconstruct.sv
hdl/green_mask.sv
hdl/centroid_tracker.sv
hdl/tracker_regs.sv
hdl/camera_tracker_top.sv
sim/cam_tracker_assertions.sv
sim/tb_camera_tracker.sv

/* Bender.yml */
package:
  name: camera_tracker

sources:
  # package first, then datapath and control, top level last
  - include_dirs:
      - hdl
    files:
      - hdl/cam_tracker_pkg.sv
      - hdl/pixel_reconstruct.sv
      - hdl/green_mask.sv
      - hdl/centroid_tracker.sv
      - hdl/tracker_regs.sv
      - hdl/camera_tracker_top.sv

  # testbench and bound checks
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/cam_tracker_assertions.sv
      - sim/tb_camera_tracker.sv

/* sim/tb_camera_tracker.sv */
`timescale 1ns/100ps
`include "cam_tracker_consts.svh"

module tb_camera_tracker;

  localparam int WAIT_LIMIT = 4000;
  localparam int NUM_ROWS   = 8;

  // one test frame, rectangle bounds are inclusive
  typedef struct packed {
    logic [7:0]  width;
    logic [7:0]  height;
    logic [7:0]  x0;
    logic [7:0]  x1;
    logic [7:0]  y0;
    logic [7:0]  y1;
    logic [15:0] player;
    logic [15:0] backgnd;
    logic [23:0] thresh;
    logic        enable;
    logic        noise;
    logic        counts;
  } frame_row_t;

  logic                       clk_camera;
  logic                       recent_reset;
  logic [7:0]                 cam_data;
  logic                       cam_pclk;
  logic                       cam_hsync;
  logic                       cam_vsync;
  cam_tracker_pkg::axil_req_t axil_req;
  cam_tracker_pkg::axil_rsp_t axil_rsp;
  logic                       result_valid;

  frame_row_t rows [NUM_ROWS];
  integer     seed = 32'h2f982f52;

  camera_tracker_top dut0 (
    .clk_camera     (clk_camera),
    .recent_reset   (recent_reset),
    .cam_data_i     (cam_data),
    .cam_pclk_i     (cam_pclk),
    .cam_hsync_i    (cam_hsync),
    .cam_vsync_i    (cam_vsync),
    .axil_req_i     (axil_req),
    .axil_rsp_o     (axil_rsp),
    .result_valid_o (result_valid)
  );

  initial begin
    clk_camera = 1'b0;
    forever #50 clk_camera = ~clk_camera;
  end

  // ==========================================================================
  // checking and failure
  // ==========================================================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns %s", $time, why);
    $display("Regression failed");
    $fatal(1, "stopping on timeout");
  endtask

  // a bound assertion failure ends the run at once
  always @(dut0.asrt0.err_count) begin
    if (dut0.asrt0.err_count != 0) begin
      $display("%0t ns a bound assertion failed", $time);
      $display("Regression failed");
      $fatal(1, "stopping on assertion failure");
    end
  end

  // ==========================================================================
  // AXI4-Lite master, everything moves on the falling edge
  // ==========================================================================

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    int n;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    n = 0;
    while (!axil_rsp.awready) begin
      @(negedge clk_camera);
      n++;
      if (n > WAIT_LIMIT) abort_run("no awready for a write");
    end
    // ready seen, the next rising edge takes AW and W
    @(negedge clk_camera);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid) begin
      @(negedge clk_camera);
      n++;
      if (n > WAIT_LIMIT) abort_run("no write response");
    end
    check_value("bresp", 32'(axil_rsp.bresp), 32'(`AXIL_RESP_OKAY));
    // response left waiting one cycle before bready
    @(negedge clk_camera);
    axil_req.bready = 1'b1;
    @(negedge clk_camera);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    n = 0;
    while (!axil_rsp.arready) begin
      @(negedge clk_camera);
      n++;
      if (n > WAIT_LIMIT) abort_run("no arready for a read");
    end
    @(negedge clk_camera);
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid) begin
      @(negedge clk_camera);
      n++;
      if (n > WAIT_LIMIT) abort_run("no read response");
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    // data left waiting one cycle before rready
    @(negedge clk_camera);
    axil_req.rready = 1'b1;
    @(negedge clk_camera);
    axil_req.rready = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_value({name, " rresp"}, 32'(resp), 32'(exp_resp));
    check_value(name, data, exp_data);
  endtask

  // ==========================================================================
  // camera bus model
  // ==========================================================================

  // green above the upper bound, red and blue anything
  function automatic logic [15:0] noise_colour(input logic [7:0] green_upper);
    int         gmin;
    int         r;
    logic [5:0] green;
    gmin  = int'(green_upper) / 4 + 1;
    r     = $random(seed);
    green = 6'(gmin + (int'(r[21:16]) % (64 - gmin)));
    return {r[4:0], green, r[9:5]};
  endfunction

  function automatic logic [15:0] pixel_colour(input frame_row_t row, input int x,
                                               input int y);
    if (x >= row.x0 && x <= row.x1 && y >= row.y0 && y <= row.y1) begin
      return row.player;
    end
    return row.noise ? noise_colour(row.thresh[7:0]) : row.backgnd;
  endfunction

  // one byte every 4 clocks, data settles while pclk is low
  task automatic send_byte(input logic [7:0] b);
    cam_data = b;
    cam_pclk = 1'b0;
    repeat (2) @(negedge clk_camera);
    cam_pclk = 1'b1;
    repeat (2) @(negedge clk_camera);
  endtask

  task automatic send_frame(input frame_row_t row);
    logic [15:0] c;
    for (int y = 0; y < row.height; y++) begin
      cam_hsync = 1'b1;
      repeat (4) @(negedge clk_camera);
      for (int x = 0; x < row.width; x++) begin
        c = pixel_colour(row, x, y);
        // high byte first
        send_byte(c[15:8]);
        send_byte(c[7:0]);
      end
      cam_pclk  = 1'b0;
      cam_hsync = 1'b0;
      repeat (8) @(negedge clk_camera);
    end
  endtask

  // vsync rise ends the frame, then wait for the tracker's strobe
  task automatic finish_frame();
    int n;
    cam_vsync = 1'b1;
    n = 0;
    while (!result_valid) begin
      @(negedge clk_camera);
      n++;
      if (n > WAIT_LIMIT) abort_run("no result after frame end");
    end
    @(negedge clk_camera);
    cam_vsync = 1'b0;
    repeat (8) @(negedge clk_camera);
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  // thresh is {blue lower, red lower, green upper}, counts says the player colour passes
  task automatic load_table();
    // w, h, x0, x1, y0, y1, player, background, thresh, enable, noise, counts
    rows[0] = '{8'd8, 8'd6, 8'd2, 8'd4, 8'd1, 8'd3,
                16'hF800, 16'h07E0, 24'h004080, 1'b1, 1'b1, 1'b1};
    // odd sums, floor of the average
    rows[1] = '{8'd10, 8'd8, 8'd5, 8'd8, 8'd2, 8'd6,
                16'hF81F, 16'h07E0, 24'h404080, 1'b1, 1'b1, 1'b1};
    // every channel sits exactly on its bound
    rows[2] = '{8'd6, 8'd4, 8'd0, 8'd2, 8'd2, 8'd3,
                16'h4404, 16'h07E0, 24'h204080, 1'b1, 1'b1, 1'b1};
    // green, red, blue each one step outside
    rows[3] = '{8'd6, 8'd4, 8'd0, 8'd2, 8'd2, 8'd3,
                16'h4424, 16'h07E0, 24'h204080, 1'b1, 1'b1, 1'b0};
    rows[4] = '{8'd6, 8'd4, 8'd0, 8'd2, 8'd2, 8'd3,
                16'h3C04, 16'h07E0, 24'h204080, 1'b1, 1'b1, 1'b0};
    rows[5] = '{8'd6, 8'd4, 8'd0, 8'd2, 8'd2, 8'd3,
                16'h4403, 16'h07E0, 24'h204080, 1'b1, 1'b1, 1'b0};
    // tracking off
    rows[6] = '{8'd8, 8'd6, 8'd1, 8'd5, 8'd0, 8'd4,
                16'hF81F, 16'h07E0, 24'h404080, 1'b0, 1'b1, 1'b1};
    // plain green everywhere
    rows[7] = '{8'd8, 8'd6, 8'd0, 8'd7, 8'd0, 8'd5,
                16'h07E0, 16'h07E0, 24'h004080, 1'b1, 1'b0, 1'b0};
  endtask

  initial begin : main
    int   cnt;
    int   sx;
    int   sy;
    int   exp_x;
    int   exp_y;
    int   frames;
    logic exp_none;

    recent_reset = 1'b1;
    cam_data     = 8'h00;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    axil_req     = '0;
    load_table();
    repeat (16) @(negedge clk_camera);
    recent_reset = 1'b0;

    // reset values and an unmapped offset
    read_expect("REG_COM", `REG_COM, 32'h0, `AXIL_RESP_OKAY);
    read_expect("REG_STATUS", `REG_STATUS, 32'h0, `AXIL_RESP_OKAY);
    read_expect("REG_THRESH", `REG_THRESH, `THRESH_RESET, `AXIL_RESP_OKAY);
    read_expect("unmapped 0x14", 8'h14, 32'h0, `AXIL_RESP_SLVERR);

    // write and read back, then a single byte lane
    axil_write(`REG_CTRL, 32'h0000_0001, 4'hF);
    read_expect("REG_CTRL", `REG_CTRL, 32'h0000_0001, `AXIL_RESP_OKAY);
    axil_write(`REG_THRESH, 32'hAB12_3456, 4'hF);
    read_expect("REG_THRESH", `REG_THRESH, 32'h0012_3456, `AXIL_RESP_OKAY);
    axil_write(`REG_THRESH, 32'hFFFF_99FF, 4'b0010);
    read_expect("REG_THRESH", `REG_THRESH, 32'h0012_9956, `AXIL_RESP_OKAY);

    exp_x  = 0;
    exp_y  = 0;
    frames = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      axil_write(`REG_THRESH, {8'h00, rows[i].thresh}, 4'hF);
      axil_write(`REG_CTRL, {31'b0, rows[i].enable}, 4'h1);

      // centre of mass is floor(sum / count) over the rectangle
      cnt = 0;
      sx  = 0;
      sy  = 0;
      if (rows[i].enable && rows[i].counts) begin
        for (int y = rows[i].y0; y <= rows[i].y1; y++) begin
          for (int x = rows[i].x0; x <= rows[i].x1; x++) begin
            sx += x;
            sy += y;
            cnt++;
          end
        end
      end
      exp_none = (cnt == 0);
      // an empty frame keeps the last position
      if (!exp_none) begin
        exp_x = sx / cnt;
        exp_y = sy / cnt;
      end
      frames++;

      send_frame(rows[i]);
      finish_frame();

      read_expect("REG_PIXCOUNT", `REG_PIXCOUNT, 32'(cnt), `AXIL_RESP_OKAY);
      read_expect("REG_COM", `REG_COM,
                  {6'b0, 10'(exp_y), 5'b0, 11'(exp_x)}, `AXIL_RESP_OKAY);
      read_expect("REG_STATUS", `REG_STATUS,
                  {16'(frames), 15'b0, exp_none}, `AXIL_RESP_OKAY);
    end

    if (dut0.asrt0.err_count != 0) begin
      $display("%0d bound assertion failures during the run", dut0.asrt0.err_count);
      $display("Regression failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

/* sim/cam_tracker_assertions.sv */
`timescale 1ns/100ps

module cam_tracker_assertions (
  input logic                       clk_camera,
  input logic                       recent_reset,
  input cam_tracker_pkg::axil_req_t req_i,
  input cam_tracker_pkg::axil_rsp_t rsp_i,
  input logic                       result_valid_i
);

  // failure count, watched by the testbench
  int unsigned err_count = 0;

  // write response stays up until the master takes it
  bvalid_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
    else begin
      $error("bvalid dropped before bready");
      err_count++;
    end

  // read response likewise
  rvalid_hold: assert property (@(posedge clk_camera) disable iff (recent_reset)
    rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
    else begin
      $error("rvalid dropped before rready");
      err_count++;
    end

  // AW and W are accepted together for one cycle, only while both are offered
  aw_w_together: assert property (@(posedge clk_camera) disable iff (recent_reset)
    (rsp_i.awready || rsp_i.wready) |->
      (rsp_i.awready && rsp_i.wready && req_i.awvalid && req_i.wvalid) ##1 !rsp_i.awready)
    else begin
      $error("awready and wready not raised together on an offered write");
      err_count++;
    end

  // one result strobe per frame
  result_pulse: assert property (@(posedge clk_camera) disable iff (recent_reset)
    result_valid_i |=> !result_valid_i)
    else begin
      $error("result_valid held longer than one cycle");
      err_count++;
    end

endmodule

bind camera_tracker_top cam_tracker_assertions asrt0 (
  .clk_camera     (clk_camera),
  .recent_reset   (recent_reset),
  .req_i          (axil_req_i),
  .rsp_i          (axil_rsp_o),
  .result_valid_i (result_valid_o)
);

/* hdl/camera_tracker_top.sv */
`timescale 1ns/100ps

module camera_tracker_top (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  logic [7:0]                 cam_data_i,
  input  logic                       cam_pclk_i,
  input  logic                       cam_hsync_i,
  input  logic                       cam_vsync_i,
  input  cam_tracker_pkg::axil_req_t axil_req_i,
  output cam_tracker_pkg::axil_rsp_t axil_rsp_o,
  output logic                       result_valid_o
);

  cam_tracker_pkg::pixel_beat_t  pixel_beat;
  cam_tracker_pkg::mask_beat_t   mask_beat;
  cam_tracker_pkg::mask_cfg_t    mask_cfg;
  cam_tracker_pkg::com_result_t  com_result;

  // control and status
  tracker_regs regs0 (
    .clk_camera     (clk_camera),
    .recent_reset   (recent_reset),
    .axil_req_i     (axil_req_i),
    .result_i       (com_result),
    .result_valid_i (result_valid_o),
    .axil_rsp_o     (axil_rsp_o),
    .cfg_o          (mask_cfg)
  );

  // camera pins to pixels, then mask, then centre of mass
  pixel_reconstruct recon0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_data_i   (cam_data_i),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .pixel_o      (pixel_beat)
  );

  green_mask mask0 (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pixel_i      (pixel_beat),
    .cfg_i        (mask_cfg),
    .mask_o       (mask_beat)
  );

  centroid_tracker com0 (
    .clk_camera     (clk_camera),
    .recent_reset   (recent_reset),
    .mask_i         (mask_beat),
    .enable_i       (mask_cfg.enable),
    .result_o       (com_result),
    .result_valid_o (result_valid_o)
  );

endmodule

/* hdl/tracker_regs.sv */
`timescale 1ns/100ps
`include "cam_tracker_consts.svh"

module tracker_regs (
  input  logic                         clk_camera,
  input  logic                         recent_reset,
  input  cam_tracker_pkg::axil_req_t   axil_req_i,
  input  cam_tracker_pkg::com_result_t result_i,
  input  logic                         result_valid_i,
  output cam_tracker_pkg::axil_rsp_t   axil_rsp_o,
  output cam_tracker_pkg::mask_cfg_t   cfg_o
);

  // ========================================================================
  // AXI4-Lite handshakes
  // ========================================================================

  logic                    aw_w_ready_q;
  logic                    bvalid_q;
  logic [1:0]              bresp_q;
  logic                    arready_q;
  logic                    rvalid_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  logic [1:0]              rresp_q;

  // AW and W are taken together, and only with no write response pending
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      aw_w_ready_q <= 1'b0;
      bvalid_q     <= 1'b0;
      arready_q    <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      aw_w_ready_q <= ~aw_w_ready_q & ~bvalid_q &
                      axil_req_i.awvalid & axil_req_i.wvalid;
      if (aw_w_ready_q) begin
        bvalid_q <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      arready_q <= ~arready_q & ~rvalid_q & axil_req_i.arvalid;
      if (arready_q) begin
        rvalid_q <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // ========================================================================
  // register file
  // ========================================================================

  logic                       ctrl_en_q;
  logic [23:0]                thresh_q;
  logic [`CAM_HCOUNT_W-1:0]   com_x_q;
  logic [`CAM_VCOUNT_W-1:0]   com_y_q;
  logic [`CAM_PIXCOUNT_W-1:0] pixcount_q;
  logic                       no_player_q;
  logic [15:0]                frame_cnt_q;

  logic                    wr_ok;
  logic                    rd_ok;
  logic [`AXIL_DATA_W-1:0] rd_word;

  // every mapped offset accepts a write, only CTRL and THRESH keep it
  always_comb begin
    case (axil_req_i.awaddr)
      `REG_CTRL, `REG_THRESH, `REG_STATUS, `REG_COM, `REG_PIXCOUNT: wr_ok = 1'b1;
      default: wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rd_ok = 1'b1;
    case (axil_req_i.araddr)
      `REG_CTRL:     rd_word = {31'b0, ctrl_en_q};
      `REG_THRESH:   rd_word = {8'b0, thresh_q};
      `REG_STATUS:   rd_word = {frame_cnt_q, 15'b0, no_player_q};
      `REG_COM:      rd_word = {6'b0, com_y_q, 5'b0, com_x_q};
      `REG_PIXCOUNT: rd_word = {12'b0, pixcount_q};
      default: begin
        rd_word = '0;
        rd_ok   = 1'b0;
      end
    endcase
  end

  // response payload follows the handshake cycle
  always_ff @(posedge clk_camera) begin
    if (aw_w_ready_q) begin
      bresp_q <= wr_ok ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
    end
    if (arready_q) begin
      rdata_q <= rd_word;
      rresp_q <= rd_ok ? `AXIL_RESP_OKAY : `AXIL_RESP_SLVERR;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      ctrl_en_q   <= 1'b0;
      thresh_q    <= 24'(`THRESH_RESET);
      com_x_q     <= '0;
      com_y_q     <= '0;
      pixcount_q  <= '0;
      no_player_q <= 1'b0;
      frame_cnt_q <= '0;
    end else begin
      if (aw_w_ready_q && axil_req_i.awaddr == `REG_CTRL && axil_req_i.wstrb[0]) begin
        ctrl_en_q <= axil_req_i.wdata[0];
      end
      // byte lanes 0..2 hold green upper, red lower, blue lower
      if (aw_w_ready_q && axil_req_i.awaddr == `REG_THRESH) begin
        for (int b = 0; b < 3; b++) begin
          if (axil_req_i.wstrb[b]) begin
            thresh_q[b*8 +: 8] <= axil_req_i.wdata[b*8 +: 8];
          end
        end
      end
      // the tracker already holds x and y on an empty frame
      if (result_valid_i) begin
        com_x_q     <= result_i.x;
        com_y_q     <= result_i.y;
        pixcount_q  <= result_i.pixcount;
        no_player_q <= result_i.no_player;
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
    end
  end

  assign cfg_o = '{green_upper: thresh_q[7:0],
                   red_lower:   thresh_q[15:8],
                   blue_lower:  thresh_q[23:16],
                   enable:      ctrl_en_q};

  assign axil_rsp_o = '{awready: aw_w_ready_q,
                        wready:  aw_w_ready_q,
                        bresp:   bresp_q,
                        bvalid:  bvalid_q,
                        arready: arready_q,
                        rdata:   rdata_q,
                        rresp:   rresp_q,
                        rvalid:  rvalid_q};

endmodule

/* hdl/centroid_tracker.sv */
`timescale 1ns/100ps
`include "cam_tracker_consts.svh"

module centroid_tracker (
  input  logic                         clk_camera,
  input  logic                         recent_reset,
  input  cam_tracker_pkg::mask_beat_t  mask_i,
  input  logic                         enable_i,
  output cam_tracker_pkg::com_result_t result_o,
  output logic                         result_valid_o
);

  localparam int DIV_W = 32;
  localparam int CNT_W = `CAM_PIXCOUNT_W;

  localparam logic [1:0] DIV_IDLE = 2'd0;
  localparam logic [1:0] DIV_X    = 2'd1;
  localparam logic [1:0] DIV_Y    = 2'd2;

  // ========================================================================
  // per-frame accumulation
  // ========================================================================

  logic [`CAM_SUM_X_W-1:0] sum_x_q;
  logic [`CAM_SUM_Y_W-1:0] sum_y_q;
  logic [CNT_W-1:0]        count_q;
  logic                    add_pixel;

  assign add_pixel = mask_i.valid & mask_i.is_player & enable_i;

  // a frame end always clears, even if the divider cannot take the sums
  always_ff @(posedge clk_camera) begin
    if (recent_reset || mask_i.frame_done) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      count_q <= '0;
    end else if (add_pixel) begin
      sum_x_q <= sum_x_q + `CAM_SUM_X_W'(mask_i.hcount);
      sum_y_q <= sum_y_q + `CAM_SUM_Y_W'(mask_i.vcount);
      count_q <= count_q + 1'b1;
    end
  end

  // ========================================================================
  // restoring divider, x first then y
  // ========================================================================

  logic [1:0]              state_q;
  logic [4:0]              step_q;
  logic                    start;
  logic                    last_step;
  logic [DIV_W-1:0]        quot_q;
  logic [CNT_W-1:0]        rem_q;
  logic [CNT_W-1:0]        divisor_q;
  logic [`CAM_SUM_Y_W-1:0] sum_y_hold_q;
  logic [CNT_W:0]          rem_shift;
  logic                    fits;
  logic [CNT_W-1:0]        rem_next;
  logic [DIV_W-1:0]        quot_next;

  // frame ends that land during a division are dropped
  assign start     = mask_i.frame_done & (state_q == DIV_IDLE);
  assign last_step = (step_q == 5'(DIV_W - 1));

  // one quotient bit per cycle, dividend shifts out of the top of quot_q
  assign rem_shift = {rem_q, quot_q[DIV_W-1]};
  assign fits      = (rem_shift >= {1'b0, divisor_q});
  assign rem_next  = fits ? CNT_W'(rem_shift - {1'b0, divisor_q}) : rem_shift[CNT_W-1:0];
  assign quot_next = {quot_q[DIV_W-2:0], fits};

  logic [`CAM_HCOUNT_W-1:0] res_x_q;
  logic [`CAM_VCOUNT_W-1:0] res_y_q;
  logic [CNT_W-1:0]         res_count_q;
  logic                     res_none_q;
  logic                     res_valid_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state_q     <= DIV_IDLE;
      step_q      <= '0;
      res_x_q     <= '0;
      res_y_q     <= '0;
      res_count_q <= '0;
      res_none_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= 1'b0;
      case (state_q)
        DIV_IDLE: begin
          if (mask_i.frame_done) begin
            res_count_q <= count_q;
            res_none_q  <= (count_q == '0);
            step_q      <= '0;
            // empty frame reports at once and keeps the last position
            if (count_q == '0) begin
              res_valid_q <= 1'b1;
            end else begin
              state_q <= DIV_X;
            end
          end
        end
        DIV_X: begin
          step_q <= step_q + 1'b1;
          if (last_step) begin
            res_x_q <= quot_next[`CAM_HCOUNT_W-1:0];
            state_q <= DIV_Y;
          end
        end
        DIV_Y: begin
          step_q <= step_q + 1'b1;
          if (last_step) begin
            res_y_q     <= quot_next[`CAM_VCOUNT_W-1:0];
            res_valid_q <= 1'b1;
            state_q     <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // divider datapath
  always_ff @(posedge clk_camera) begin
    if (start) begin
      quot_q       <= DIV_W'(sum_x_q);
      rem_q        <= '0;
      divisor_q    <= count_q;
      sum_y_hold_q <= sum_y_q;
    end else if (state_q == DIV_X && last_step) begin
      // reload for the y pass
      quot_q <= DIV_W'(sum_y_hold_q);
      rem_q  <= '0;
    end else if (state_q != DIV_IDLE) begin
      quot_q <= quot_next;
      rem_q  <= rem_next;
    end
  end

  assign result_o = '{x:         res_x_q,
                      y:         res_y_q,
                      pixcount:  res_count_q,
                      no_player: res_none_q};
  assign result_valid_o = res_valid_q;

endmodule

/* hdl/green_mask.sv */
`timescale 1ns/100ps

module green_mask (
  input  logic                         clk_camera,
  input  logic                         recent_reset,
  input  cam_tracker_pkg::pixel_beat_t pixel_i,
  input  cam_tracker_pkg::mask_cfg_t   cfg_i,
  output cam_tracker_pkg::mask_beat_t  mask_o
);

  // RGB565 channels padded with low zeros to 8 bits
  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic       hit;

  logic       valid_q;
  logic       done_q;
  logic       player_q;
  logic [$bits(pixel_i.hcount)-1:0] hcount_q;
  logic [$bits(pixel_i.vcount)-1:0] vcount_q;

  assign red8   = {pixel_i.pixel.rgb.red, 3'b000};
  assign green8 = {pixel_i.pixel.rgb.green, 2'b00};
  assign blue8  = {pixel_i.pixel.rgb.blue, 3'b000};

  // player is anything not green enough, all bounds inclusive
  assign hit = (green8 <= cfg_i.green_upper) &&
               (red8 >= cfg_i.red_lower) &&
               (blue8 >= cfg_i.blue_lower);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      valid_q <= pixel_i.valid;
      done_q  <= pixel_i.frame_done;
    end
  end

  // position and mask bit only matter alongside valid
  always_ff @(posedge clk_camera) begin
    player_q <= hit;
    hcount_q <= pixel_i.hcount;
    vcount_q <= pixel_i.vcount;
  end

  assign mask_o = '{valid:      valid_q,
                    frame_done: done_q,
                    is_player:  player_q,
                    hcount:     hcount_q,
                    vcount:     vcount_q};

endmodule

/* hdl/pixel_reconstruct.sv */
`timescale 1ns/100ps
`include "cam_tracker_consts.svh"

module pixel_reconstruct (
  input  logic                         clk_camera,
  input  logic                         recent_reset,
  input  logic [7:0]                   cam_data_i,
  input  logic                         cam_pclk_i,
  input  logic                         cam_hsync_i,
  input  logic                         cam_vsync_i,
  output cam_tracker_pkg::pixel_beat_t pixel_o
);

  // ========================================================================
  // pin synchronisers and edge detect
  // ========================================================================

  // control lines packed as {vsync, hsync, pclk}
  logic [2:0] ctl_meta;
  logic [2:0] ctl_sync;
  logic [2:0] ctl_prev;
  logic [7:0] data_meta;
  logic [7:0] data_sync;

  // registered edge strobes, one cycle each
  logic       pclk_rise_q;
  logic       hs_rise_q;
  logic       hs_fall_q;
  logic       vs_rise_q;
  logic       hs_level_q;
  logic [7:0] byte_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      ctl_meta    <= '0;
      ctl_sync    <= '0;
      ctl_prev    <= '0;
      pclk_rise_q <= 1'b0;
      hs_rise_q   <= 1'b0;
      hs_fall_q   <= 1'b0;
      vs_rise_q   <= 1'b0;
      hs_level_q  <= 1'b0;
    end else begin
      ctl_meta    <= {cam_vsync_i, cam_hsync_i, cam_pclk_i};
      ctl_sync    <= ctl_meta;
      ctl_prev    <= ctl_sync;
      pclk_rise_q <= ctl_sync[0] & ~ctl_prev[0];
      hs_rise_q   <= ctl_sync[1] & ~ctl_prev[1];
      hs_fall_q   <= ~ctl_sync[1] & ctl_prev[1];
      vs_rise_q   <= ctl_sync[2] & ~ctl_prev[2];
      hs_level_q  <= ctl_sync[1];
    end
  end

  // data rides through the same two stages as pclk
  always_ff @(posedge clk_camera) begin
    data_meta <= cam_data_i;
    data_sync <= data_meta;
    byte_q    <= data_sync;
  end

  // ========================================================================
  // byte pairing and position counts
  // ========================================================================

  logic                     take_byte;
  logic                     low_byte;
  // set while the high byte of a pair is held
  logic                     phase_q;
  logic [`CAM_HCOUNT_W-1:0] hpos_q;
  logic [`CAM_VCOUNT_W-1:0] line_q;
  logic                     beat_valid_q;
  logic                     beat_done_q;
  logic [`CAM_HCOUNT_W-1:0] beat_h_q;
  logic [`CAM_VCOUNT_W-1:0] beat_v_q;
  cam_tracker_pkg::pixel_word_u word_q;

  // bytes only count inside an active line
  assign take_byte = pclk_rise_q & hs_level_q;
  // a line start always opens a new pair
  assign low_byte  = take_byte & phase_q & ~hs_rise_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase_q      <= 1'b0;
      hpos_q       <= '0;
      line_q       <= '0;
      beat_valid_q <= 1'b0;
      beat_done_q  <= 1'b0;
    end else begin
      beat_valid_q <= low_byte;
      beat_done_q  <= vs_rise_q;
      if (vs_rise_q) begin
        // new frame, everything restarts at the top left
        phase_q <= 1'b0;
        hpos_q  <= '0;
        line_q  <= '0;
      end else begin
        if (take_byte | hs_rise_q) begin
          phase_q <= take_byte & ~low_byte;
        end
        if (hs_fall_q) begin
          hpos_q <= '0;
          // count completed lines, held at the last legal row
          if (line_q != `CAM_VCOUNT_W'(`CAM_MAX_HEIGHT - 1)) begin
            line_q <= line_q + 1'b1;
          end
        end else if (low_byte && hpos_q != `CAM_HCOUNT_W'(`CAM_MAX_WIDTH - 1)) begin
          hpos_q <= hpos_q + 1'b1;
        end
      end
    end
  end

  // assembly through the byte view of the word
  always_ff @(posedge clk_camera) begin
    if (take_byte && !low_byte) begin
      word_q.bytes.hi <= byte_q;
    end
    if (low_byte) begin
      word_q.bytes.lo <= byte_q;
      beat_h_q        <= hpos_q;
      beat_v_q        <= line_q;
    end
  end

  assign pixel_o = '{valid:      beat_valid_q,
                     frame_done: beat_done_q,
                     hcount:     beat_h_q,
                     vcount:     beat_v_q,
                     pixel:      word_q};

endmodule

/* hdl/cam_tracker_pkg.sv */
`include "cam_tracker_consts.svh"

package cam_tracker_pkg;

  // one 16-bit camera word, seen as raw bytes or as RGB565
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } pixel_bytes_t;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef union packed {
    pixel_bytes_t bytes;
    rgb565_t      rgb;
  } pixel_word_u;

  // a pixel, or a frame end marker when frame_done is set
  typedef struct packed {
    logic                       valid;
    logic                       frame_done;
    logic [`CAM_HCOUNT_W-1:0]   hcount;
    logic [`CAM_VCOUNT_W-1:0]   vcount;
    pixel_word_u                pixel;
  } pixel_beat_t;

  typedef struct packed {
    logic                       valid;
    logic                       frame_done;
    logic                       is_player;
    logic [`CAM_HCOUNT_W-1:0]   hcount;
    logic [`CAM_VCOUNT_W-1:0]   vcount;
  } mask_beat_t;

  typedef struct packed {
    logic [7:0] green_upper;
    logic [7:0] red_lower;
    logic [7:0] blue_lower;
    logic       enable;
  } mask_cfg_t;

  typedef struct packed {
    logic [`CAM_HCOUNT_W-1:0]   x;
    logic [`CAM_VCOUNT_W-1:0]   y;
    logic [`CAM_PIXCOUNT_W-1:0] pixcount;
    logic                       no_player;
  } com_result_t;

  // AXI4-Lite, master to slave
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0]   awaddr;
    logic                      awvalid;
    logic [`AXIL_DATA_W-1:0]   wdata;
    logic [`AXIL_DATA_W/8-1:0] wstrb;
    logic                      wvalid;
    logic                      bready;
    logic [`AXIL_ADDR_W-1:0]   araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_req_t;

  // AXI4-Lite, slave to master
  typedef struct packed {
    logic                    awready;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    arready;
    logic [`AXIL_DATA_W-1:0] rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
  } axil_rsp_t;

endpackage

/* hdl/cam_tracker_consts.svh */
`ifndef CAM_TRACKER_CONSTS_SVH
`define CAM_TRACKER_CONSTS_SVH

// largest frame the camera path is sized for
`define CAM_MAX_WIDTH 1280
`define CAM_MAX_HEIGHT 720

// pixel position counts
`define CAM_HCOUNT_W 11
`define CAM_VCOUNT_W 10

// per-frame coordinate sums, wide enough for a full 1280x720 frame of player
`define CAM_SUM_X_W 31
`define CAM_SUM_Y_W 30
`define CAM_PIXCOUNT_W 20

// control bus
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32
`define AXIL_RESP_OKAY 2'b00
`define AXIL_RESP_SLVERR 2'b10

// register map
`define REG_CTRL 8'h00
`define REG_THRESH 8'h04
`define REG_STATUS 8'h08
`define REG_COM 8'h0C
`define REG_PIXCOUNT 8'h10

// green upper 255, red and blue lower 0
`define THRESH_RESET 32'h0000_00FF

`endif
